/* hw/cell_pkg.sv */
`default_nettype none

package cell_pkg;

    ////////////////////////////////////////////////////////////////////
    // Array geometry
    ////////////////////////////////////////////////////////////////////

    // Power of two, at most 8 so a cell number fits in first_hit
    parameter int N_CELLS = 8;

    ////////////////////////////////////////////////////////////////////
    // Command and answer types
    ////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        op_update     = 3'd0,
        op_lookup     = 3'd1,
        op_encode     = 3'd2,
        op_shift_up   = 3'd3,
        op_shift_down = 3'd4,
        op_find_free  = 3'd5,
        op_rank       = 3'd6,
        op_range      = 3'd7
    } cell_op_e;

    typedef struct packed {
        cell_op_e   op;
        logic [7:0] target;
        logic [7:0] key;
        logic       key_valid;
        logic [7:0] value;
    } cell_cmd_t;

    // Per-cell answer, one cycle after the broadcast
    typedef struct packed {
        logic       hit;
        logic [7:0] result;
        logic [7:0] ctx;
    } cell_ans_t;

    // Reduced answer of the whole array
    typedef struct packed {
        logic       any_hit;
        logic [3:0] hit_count;
        logic [2:0] first_hit;
        logic [7:0] result;
        logic [7:0] ctx;
    } array_result_t;

endpackage

`default_nettype wire

/* hw/cmd_decoder.sv */
`default_nettype none

module cmd_decoder (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                cmd_valid,
    input  cell_pkg::cell_cmd_t      cmd,
    output logic                     bcast_valid,
    output cell_pkg::cell_cmd_t      bcast_cmd
);

    // A lookup without key never hits and never writes
    localparam cell_pkg::cell_cmd_t IDLE_CMD = '{
        op:        cell_pkg::op_lookup,
        target:    8'h00,
        key:       8'h00,
        key_valid: 1'b0,
        value:     8'h00
    };

    cell_pkg::cell_cmd_t cmd_nxt;

    ////////////////////////////////////////////////////////////////////
    // Idle cycles turn into a no-op broadcast
    ////////////////////////////////////////////////////////////////////

    always_comb begin
        cmd_nxt = cmd;
        if (!cmd_valid) begin
            cmd_nxt.op        = cell_pkg::op_lookup;
            cmd_nxt.key_valid = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bcast_valid <= 1'b0;
            bcast_cmd   <= IDLE_CMD;
        end else begin
            bcast_valid <= cmd_valid;
            bcast_cmd   <= cmd_nxt;
        end
    end

endmodule

`default_nettype wire

/* hw/assoc_cell.sv */
`default_nettype none

module assoc_cell #(
    parameter logic [7:0] HANDLE = 8'd0
) (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  cell_pkg::cell_cmd_t   cmd,
    output cell_pkg::cell_ans_t   ans
);

    // Descriptor and element state
    logic       arr_def;
    logic       elt_def;
    logic [7:0] array_code;
    logic [7:0] rank;
    logic [7:0] low;
    logic [7:0] high;
    logic [7:0] index;
    logic [7:0] value;

    logic       arr_def_nxt;
    logic       elt_def_nxt;
    logic [7:0] array_code_nxt;
    logic [7:0] rank_nxt;
    logic [7:0] low_nxt;
    logic [7:0] high_nxt;
    logic [7:0] index_nxt;
    logic [7:0] value_nxt;

    cell_pkg::cell_ans_t ans_nxt;

    logic is_target;
    logic key_match;
    logic key_hit;
    logic key_in_range;

    assign is_target    = (cmd.target == HANDLE);
    assign key_match    = (cmd.key == HANDLE);
    assign key_hit      = cmd.key_valid && key_match;
    assign key_in_range = cmd.key_valid && (cmd.key >= low) && (cmd.key <= high);

    ////////////////////////////////////////////////////////////////////
    // Operation decode
    ////////////////////////////////////////////////////////////////////

    always_comb begin
        arr_def_nxt    = arr_def;
        elt_def_nxt    = elt_def;
        array_code_nxt = array_code;
        rank_nxt       = rank;
        low_nxt        = low;
        high_nxt       = high;
        index_nxt      = index;
        value_nxt      = value;
        ans_nxt        = '0;

        case (cmd.op)
            cell_pkg::op_update: begin
                ans_nxt.hit    = key_hit;
                ans_nxt.result = HANDLE;
                ans_nxt.ctx    = HANDLE;
                if (key_hit) begin
                    arr_def_nxt    = 1'b1;
                    elt_def_nxt    = 1'b1;
                    array_code_nxt = HANDLE;
                    low_nxt        = HANDLE;
                    high_nxt       = HANDLE;
                    index_nxt      = cmd.target;
                    value_nxt      = cmd.value;
                    rank_nxt       = 8'd1;
                end
            end
            cell_pkg::op_lookup: begin
                ans_nxt.hit    = elt_def && (index == cmd.target) && key_in_range;
                ans_nxt.result = value;
                ans_nxt.ctx    = rank;
            end
            cell_pkg::op_encode: begin
                ans_nxt.hit    = arr_def && key_hit;
                ans_nxt.result = array_code;
                ans_nxt.ctx    = array_code;
            end
            cell_pkg::op_shift_up: begin
                if (is_target) begin
                    if (cmd.key_valid) begin
                        array_code_nxt = cmd.key + 8'd1;
                        low_nxt        = cmd.key + 8'd1;
                        high_nxt       = cmd.key + 8'd1;
                        rank_nxt       = cmd.value + 8'd1;
                    end
                end else if (cmd.key_valid) begin
                    if (arr_def && (array_code > cmd.key))
                        array_code_nxt = array_code + 8'd1;
                    if (elt_def && (low > cmd.key))
                        low_nxt = low + 8'd1;
                    if (elt_def && (high >= cmd.key))
                        high_nxt = high + 8'd1;
                end
            end
            cell_pkg::op_shift_down: begin
                if (is_target) begin
                    arr_def_nxt = 1'b0;
                    rank_nxt    = 8'd0;
                end
                if (elt_def) begin
                    // Key below the range moves it down, key inside shrinks it
                    if (cmd.key_valid && (cmd.key < low)) begin
                        low_nxt  = low - 8'd1;
                        high_nxt = high - 8'd1;
                    end else if (key_in_range) begin
                        high_nxt = high - 8'd1;
                    end
                    if (low_nxt > high_nxt) begin
                        elt_def_nxt = 1'b0;
                        arr_def_nxt = 1'b0;
                    end
                end
                if (arr_def && cmd.key_valid && (array_code > cmd.key))
                    array_code_nxt = array_code - 8'd1;
            end
            cell_pkg::op_find_free: begin
                ans_nxt.hit    = !elt_def;
                ans_nxt.result = HANDLE;
                ans_nxt.ctx    = HANDLE;
            end
            cell_pkg::op_rank: begin
                ans_nxt.hit    = arr_def && key_hit;
                ans_nxt.result = rank;
                ans_nxt.ctx    = rank;
            end
            cell_pkg::op_range: begin
                // key_valid selects the upper bound
                ans_nxt.hit    = elt_def && key_match;
                ans_nxt.result = cmd.key_valid ? high : low;
                ans_nxt.ctx    = cmd.key_valid ? high : low;
            end
            default: ans_nxt = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            arr_def    <= 1'b0;
            elt_def    <= 1'b0;
            array_code <= 8'd0;
            rank       <= 8'd0;
            low        <= 8'd0;
            high       <= 8'd0;
            index      <= 8'd0;
            value      <= 8'd0;
            ans        <= '0;
        end else begin
            arr_def    <= arr_def_nxt;
            elt_def    <= elt_def_nxt;
            array_code <= array_code_nxt;
            rank       <= rank_nxt;
            low        <= low_nxt;
            high       <= high_nxt;
            index      <= index_nxt;
            value      <= value_nxt;
            ans        <= ans_nxt;
        end
    end

endmodule

`default_nettype wire

/* hw/match_reducer.sv */
`default_nettype none

module match_reducer #(
    parameter int N_CELLS = 8
) (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                ans_valid,
    input  cell_pkg::cell_ans_t      ans [N_CELLS],
    output logic                     res_valid,
    output cell_pkg::array_result_t  res
);

    cell_pkg::array_result_t res_nxt;

    ////////////////////////////////////////////////////////////////////
    // Hit count and lowest-numbered hit
    ////////////////////////////////////////////////////////////////////

    always_comb begin
        res_nxt = '0;
        for (int i = 0; i < N_CELLS; i++) begin
            if (ans[i].hit) begin
                // First hit wins, later ones only count
                if (!res_nxt.any_hit) begin
                    res_nxt.first_hit = 3'(i);
                    res_nxt.result    = ans[i].result;
                    res_nxt.ctx       = ans[i].ctx;
                end
                res_nxt.any_hit   = 1'b1;
                res_nxt.hit_count = res_nxt.hit_count + 4'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= ans_valid;
        end
    end

    // Result word only loads with a valid answer set
    always_ff @(posedge clk) begin
        if (ans_valid) begin
            res <= res_nxt;
        end
    end

endmodule

`default_nettype wire

/* hw/assoc_array_top.sv */
`default_nettype none

module assoc_array_top #(
    parameter int N_CELLS = cell_pkg::N_CELLS
) (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                cmd_valid,
    input  cell_pkg::cell_cmd_t      cmd,
    output logic                     res_valid,
    output cell_pkg::array_result_t  res
);

    logic                bcast_valid;
    cell_pkg::cell_cmd_t bcast_cmd;
    logic                ans_valid;
    cell_pkg::cell_ans_t ans [N_CELLS];

    cmd_decoder u_decoder (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd_valid   (cmd_valid),
        .cmd         (cmd),
        .bcast_valid (bcast_valid),
        .bcast_cmd   (bcast_cmd)
    );

    ////////////////////////////////////////////////////////////////////
    // Cell array, one handle per cell
    ////////////////////////////////////////////////////////////////////

    for (genvar g = 0; g < N_CELLS; g++) begin : g_cell
        assoc_cell #(
            .HANDLE (8'(g))
        ) u_cell (
            .clk   (clk),
            .rst_n (rst_n),
            .cmd   (bcast_cmd),
            .ans   (ans[g])
        );
    end

    // Valid travels beside the cell answer registers
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ans_valid <= 1'b0;
        end else begin
            ans_valid <= bcast_valid;
        end
    end

    match_reducer #(
        .N_CELLS (N_CELLS)
    ) u_reducer (
        .clk       (clk),
        .rst_n     (rst_n),
        .ans_valid (ans_valid),
        .ans       (ans),
        .res_valid (res_valid),
        .res       (res)
    );

endmodule

`default_nettype wire

/* bench/tb_assoc_array.sv */
`default_nettype none

module tb_assoc_array;

    // Cycles from driving a command to seeing its result
    localparam int LATENCY     = 3;
    localparam int RANDOM_CMDS = 600;
    localparam int DRAIN_LIMIT = 20;

    typedef struct packed {
        logic       arr_def;
        logic       elt_def;
        logic [7:0] code;
        logic [7:0] rank;
        logic [7:0] low;
        logic [7:0] high;
        logic [7:0] index;
        logic [7:0] value;
    } cell_rec_t;

    logic                    clk;
    logic                    rst_n;
    logic                    cmd_valid;
    cell_pkg::cell_cmd_t     cmd;
    logic                    res_valid;
    cell_pkg::array_result_t res;

    cell_rec_t               model [8];
    cell_pkg::array_result_t exp_q [$];
    int                      due_q [$];
    int                      cycle_cnt;
    int                      value_errors;
    int                      protocol_errors;

    assoc_array_top #(
        .N_CELLS (8)
    ) dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .res_valid (res_valid),
        .res       (res)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    //////////////////////////////////////////////////////////////////////
    // Reference model of the eight cells
    //////////////////////////////////////////////////////////////////////

    task automatic apply_model(input cell_pkg::cell_cmd_t c);
        cell_pkg::array_result_t exp;
        cell_rec_t               old;
        cell_rec_t               r;
        logic [7:0]              h;
        logic                    hit;
        logic [7:0]              ans_r;
        logic [7:0]              ans_c;
        logic                    kv;
        logic                    in_rng;
        exp = '0;
        kv  = c.key_valid;
        for (int i = 0; i < 8; i++) begin
            old    = model[i];
            r      = old;
            h      = 8'(i);
            hit    = 1'b0;
            ans_r  = 8'd0;
            ans_c  = 8'd0;
            in_rng = kv && (c.key >= old.low) && (c.key <= old.high);
            case (c.op)
                cell_pkg::op_update: begin
                    if (kv && (c.key == h)) begin
                        hit       = 1'b1;
                        ans_r     = h;
                        ans_c     = h;
                        r.arr_def = 1'b1;
                        r.elt_def = 1'b1;
                        r.code    = h;
                        r.low     = h;
                        r.high    = h;
                        r.index   = c.target;
                        r.value   = c.value;
                        r.rank    = 8'd1;
                    end
                end
                cell_pkg::op_lookup: begin
                    hit   = old.elt_def && (old.index == c.target) && in_rng;
                    ans_r = old.value;
                    ans_c = old.rank;
                end
                cell_pkg::op_encode: begin
                    hit   = old.arr_def && kv && (c.key == h);
                    ans_r = old.code;
                    ans_c = old.code;
                end
                cell_pkg::op_shift_up: begin
                    if (c.target == h) begin
                        if (kv) begin
                            r.code = c.key + 8'd1;
                            r.low  = c.key + 8'd1;
                            r.high = c.key + 8'd1;
                            r.rank = c.value + 8'd1;
                        end
                    end else if (kv) begin
                        if (old.arr_def && (old.code > c.key))
                            r.code = old.code + 8'd1;
                        if (old.elt_def && (old.low > c.key))
                            r.low = old.low + 8'd1;
                        if (old.elt_def && (old.high >= c.key))
                            r.high = old.high + 8'd1;
                    end
                end
                cell_pkg::op_shift_down: begin
                    if (c.target == h) begin
                        r.arr_def = 1'b0;
                        r.rank    = 8'd0;
                    end
                    if (old.elt_def) begin
                        if (kv && (c.key < old.low)) begin
                            r.low  = old.low - 8'd1;
                            r.high = old.high - 8'd1;
                        end else if (in_rng) begin
                            r.high = old.high - 8'd1;
                        end
                        // Range emptied
                        if (r.low > r.high) begin
                            r.elt_def = 1'b0;
                            r.arr_def = 1'b0;
                        end
                    end
                    if (old.arr_def && kv && (old.code > c.key))
                        r.code = old.code - 8'd1;
                end
                cell_pkg::op_find_free: begin
                    hit   = !old.elt_def;
                    ans_r = h;
                    ans_c = h;
                end
                cell_pkg::op_rank: begin
                    hit   = old.arr_def && kv && (c.key == h);
                    ans_r = old.rank;
                    ans_c = old.rank;
                end
                cell_pkg::op_range: begin
                    hit   = old.elt_def && (c.key == h);
                    ans_r = kv ? old.high : old.low;
                    ans_c = kv ? old.high : old.low;
                end
                default: hit = 1'b0;
            endcase
            model[i] = r;
            if (hit) begin
                if (!exp.any_hit) begin
                    exp.first_hit = 3'(i);
                    exp.result    = ans_r;
                    exp.ctx       = ans_c;
                end
                exp.any_hit   = 1'b1;
                exp.hit_count = exp.hit_count + 4'd1;
            end
        end
        exp_q.push_back(exp);
        due_q.push_back(cycle_cnt + LATENCY);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    task automatic check_result(input cell_pkg::array_result_t exp,
                                input cell_pkg::array_result_t got);
        if (got !== exp) begin
            value_errors++;
            $display("[FAIL] %0t result mismatch (exp/got) hit %0b/%0b count %0d/%0d",
                     $time, exp.any_hit, got.any_hit, exp.hit_count, got.hit_count);
            $display("[FAIL] %0t   first %0d/%0d result %h/%h ctx %h/%h", $time,
                     exp.first_hit, got.first_hit, exp.result, got.result,
                     exp.ctx, got.ctx);
        end
    endtask

    task automatic check_idle(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            if (res_valid !== 1'b0) begin
                value_errors++;
                $display("[FAIL] %0t res_valid high with no command issued", $time);
            end
            @(negedge clk);
        end
    endtask

    // Called at each falling edge, where outputs are stable
    task automatic collect_result();
        cell_pkg::array_result_t exp;
        int                      due;
        if (res_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                protocol_errors++;
                $display("A result appeared at time %0t with no command waiting for it",
                         $time);
            end else begin
                exp = exp_q.pop_front();
                due = due_q.pop_front();
                if (cycle_cnt != due) begin
                    value_errors++;
                    $display("[FAIL] %0t result at cycle %0d, expected at cycle %0d",
                             $time, cycle_cnt, due);
                end
                check_result(exp, res);
            end
        end else if (due_q.size() > 0 && cycle_cnt > due_q[0]) begin
            protocol_errors++;
            $display("A result due at cycle %0d never appeared (time %0t)",
                     due_q[0], $time);
            void'(exp_q.pop_front());
            void'(due_q.pop_front());
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    function automatic cell_pkg::cell_cmd_t make_cmd(input cell_pkg::cell_op_e op,
                                                    input logic [7:0] target,
                                                    input logic [7:0] key,
                                                    input logic kv,
                                                    input logic [7:0] value);
        cell_pkg::cell_cmd_t c;
        c.op        = op;
        c.target    = target;
        c.key       = key;
        c.key_valid = kv;
        c.value     = value;
        return c;
    endfunction

    // Keys and targets up to 9 so some miss every cell
    function automatic cell_pkg::cell_cmd_t random_cmd();
        cell_pkg::cell_cmd_t c;
        c.op        = cell_pkg::cell_op_e'(3'($urandom_range(0, 7)));
        c.target    = 8'($urandom_range(0, 9));
        c.key       = 8'($urandom_range(0, 9));
        c.key_valid = ($urandom_range(0, 9) != 0);
        c.value     = 8'($urandom);
        return c;
    endfunction

    task automatic send_cmd(input cell_pkg::cell_cmd_t c);
        collect_result();
        cmd_valid = 1'b1;
        cmd       = c;
        apply_model(c);
        @(negedge clk);
    endtask

    // Idle cycle with junk on cmd
    task automatic drive_idle();
        collect_result();
        cmd_valid = 1'b0;
        cmd       = random_cmd();
        @(negedge clk);
    endtask

    initial begin
        int wait_cnt;
        void'($urandom(32'hd933));
        rst_n           = 1'b0;
        cmd_valid       = 1'b0;
        cmd             = '0;
        cycle_cnt       = 0;
        value_errors    = 0;
        protocol_errors = 0;
        for (int i = 0; i < 8; i++)
            model[i] = '0;

        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // All cells free after reset
        check_idle(8);
        send_cmd(make_cmd(cell_pkg::op_find_free, 8'd0, 8'd0, 1'b1, 8'd0));

        // Define cell 3 and query it every way
        send_cmd(make_cmd(cell_pkg::op_update, 8'd5, 8'd3, 1'b1, 8'ha5));
        send_cmd(make_cmd(cell_pkg::op_lookup, 8'd5, 8'd3, 1'b1, 8'd0));
        send_cmd(make_cmd(cell_pkg::op_encode, 8'd0, 8'd3, 1'b1, 8'd0));
        send_cmd(make_cmd(cell_pkg::op_rank, 8'd0, 8'd3, 1'b1, 8'd0));
        send_cmd(make_cmd(cell_pkg::op_range, 8'd0, 8'd3, 1'b1, 8'd0));
        send_cmd(make_cmd(cell_pkg::op_range, 8'd0, 8'd3, 1'b0, 8'd0));

        // Shifts move codes and ranges and empty cell 3
        send_cmd(make_cmd(cell_pkg::op_update, 8'd2, 8'd6, 1'b1, 8'h3c));
        send_cmd(make_cmd(cell_pkg::op_shift_up, 8'd6, 8'd4, 1'b1, 8'd9));
        send_cmd(make_cmd(cell_pkg::op_range, 8'd0, 8'd6, 1'b1, 8'd0));
        send_cmd(make_cmd(cell_pkg::op_rank, 8'd0, 8'd6, 1'b1, 8'd0));
        send_cmd(make_cmd(cell_pkg::op_shift_down, 8'd3, 8'd3, 1'b1, 8'd0));
        drive_idle();
        send_cmd(make_cmd(cell_pkg::op_find_free, 8'd0, 8'd0, 1'b1, 8'd0));
        send_cmd(make_cmd(cell_pkg::op_lookup, 8'd2, 8'd4, 1'b1, 8'd0));

        // No key
        send_cmd(make_cmd(cell_pkg::op_update, 8'd1, 8'd1, 1'b0, 8'h77));
        send_cmd(make_cmd(cell_pkg::op_lookup, 8'd2, 8'd4, 1'b0, 8'd0));
        send_cmd(make_cmd(cell_pkg::op_encode, 8'd0, 8'd6, 1'b0, 8'd0));
        send_cmd(make_cmd(cell_pkg::op_rank, 8'd0, 8'd6, 1'b0, 8'd0));
        send_cmd(make_cmd(cell_pkg::op_range, 8'd0, 8'd6, 1'b0, 8'd0));

        // Random traffic with a command on about three cycles in four
        for (int n = 0; n < RANDOM_CMDS; n++) begin
            if ($urandom_range(0, 3) != 0)
                send_cmd(random_cmd());
            else
                drive_idle();
        end

        wait_cnt = 0;
        while (exp_q.size() > 0 && wait_cnt < DRAIN_LIMIT) begin
            drive_idle();
            wait_cnt++;
        end
        if (exp_q.size() > 0) begin
            protocol_errors++;
            $display("Timed out waiting for %0d outstanding results", exp_q.size());
        end

        $display("Error count: %0d value errors, %0d protocol errors",
                 value_errors, protocol_errors);
        if (value_errors + protocol_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
hw/cell_pkg.sv
hw/cmd_decoder.sv
hw/assoc_cell.sv
hw/match_reducer.sv
hw/assoc_array_top.sv
bench/tb_assoc_array.sv

/* Makefile */
TOP := tb_assoc_array

.PHONY: sim clean

sim:
	verilator --binary --timing -f verilog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
